// ==== common/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

    // ------------------------------------------------------------
    // Fetch datapath widths and constants
    // ------------------------------------------------------------

    // One instruction word or one byte address
    typedef logic [31:0] data_word_t;

    // Default depth of the instruction buffer, kept a power of two
    localparam int unsigned BUFFER_SIZE = 8;

    // First address fetched out of reset
    localparam data_word_t RESET_VECTOR = 32'h0000_0000;

    // Canonical no-op (addi x0, x0, 0) seen in slots never written
    localparam data_word_t NOP_WORD = 32'h0000_0013;

    // Requests in flight can exceed the buffer depth when flushes pile
    // up stale responses, so the counters get two spare bits
    localparam int unsigned INFLIGHT_BITS = $clog2(BUFFER_SIZE) + 2;

    typedef logic [INFLIGHT_BITS-1:0] inflight_cnt_t;

    // ------------------------------------------------------------
    // Fetch controller states
    // ------------------------------------------------------------

    typedef enum logic [1:0] {
        ISSUE,
        PREDICT,
        HOLD
    } fetch_state_t;

endpackage : fetch_pkg

`default_nettype wire

// ==== common/btb_pkg.sv ====
`default_nettype none

package btb_pkg;

    // ------------------------------------------------------------
    // Direct-mapped branch target buffer geometry
    // ------------------------------------------------------------

    // Word-aligned fetch so the index starts above the byte offset
    localparam int unsigned BTB_INDEX_LSB  = 2;
    localparam int unsigned BTB_INDEX_BITS = 4;
    localparam int unsigned BTB_ENTRIES    = 1 << BTB_INDEX_BITS;

    // Everything above the index is kept as the tag (bits 31:6)
    localparam int unsigned BTB_TAG_LSB  = BTB_INDEX_LSB + BTB_INDEX_BITS;
    localparam int unsigned BTB_TAG_BITS = 32 - BTB_TAG_LSB;

    typedef logic [BTB_INDEX_BITS-1:0] btb_index_t;
    typedef logic [BTB_TAG_BITS-1:0]   btb_tag_t;

    // Two-bit saturating direction counter, upper bit predicts taken
    typedef logic [1:0] btb_counter_t;

    // New entries start weakly taken
    localparam btb_counter_t WEAK_TAKEN = 2'd2;

endpackage : btb_pkg

`default_nettype wire

// ==== verilog/fetch_controller.sv ====
`default_nettype none

module fetch_controller (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  flush_i,
    input  fetch_pkg::data_word_t redirect_address_i,
    input  logic                  buffer_full_i,
    input  logic                  fetch_valid_i,
    input  logic                  predict_hit_i,
    input  logic                  predict_taken_i,
    input  fetch_pkg::data_word_t predict_target_i,
    output logic                  fetch_req_o,
    output fetch_pkg::data_word_t fetch_address_o,
    output logic                  write_address_o,
    output logic                  write_speculative_o,
    output logic                  speculative_o,
    output logic                  taken_o,
    output logic                  write_instruction_o
);
    import fetch_pkg::*;

    fetch_state_t  state_q;
    fetch_state_t  state_d;
    data_word_t    pc_q;
    data_word_t    pc_d;
    inflight_cnt_t outstanding_q;
    inflight_cnt_t discard_q;
    logic          issue;
    logic          response_live;

    // ------------------------------------------------------------
    // Program counter and state machine
    // ------------------------------------------------------------

    // A request leaves only from ISSUE with room in the buffer
    assign issue = (state_q == ISSUE) && !buffer_full_i && !flush_i;

    always_comb begin
        state_d = state_q;
        pc_d    = pc_q;

        case (state_q)
            ISSUE: begin
                // Wait out a full buffer in HOLD so the slot is not lost
                state_d = buffer_full_i ? HOLD : PREDICT;
            end

            PREDICT: begin
                // The predictor outcome for pc_q is valid this cycle
                state_d = ISSUE;
                if (predict_hit_i && predict_taken_i) begin
                    pc_d = predict_target_i;
                end else begin
                    pc_d = pc_q + 32'd4;
                end
            end

            HOLD: begin
                if (!buffer_full_i) begin
                    state_d = ISSUE;
                end
            end

            default: state_d = ISSUE;
        endcase

        // A flush overrides everything, including an outcome in PREDICT
        if (flush_i) begin
            state_d = ISSUE;
            pc_d    = redirect_address_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            // Out of reset the first request leaves from HOLD through ISSUE a cycle later
            state_q <= HOLD;
            pc_q    <= RESET_VECTOR;
        end else begin
            state_q <= state_d;
            pc_q    <= pc_d;
        end
    end

    // ------------------------------------------------------------
    // Stale response filter
    // ------------------------------------------------------------

    // Responses come back in order, so the oldest ones are the stale ones
    assign response_live = fetch_valid_i && (discard_q == '0);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            outstanding_q <= '0;
            discard_q     <= '0;
        end else if (flush_i) begin
            // Every live request becomes stale, minus any response taken now
            outstanding_q <= '0;
            discard_q     <= discard_q + outstanding_q - inflight_cnt_t'(fetch_valid_i);
        end else begin
            outstanding_q <= outstanding_q + inflight_cnt_t'(issue)
                           - inflight_cnt_t'(response_live);
            if (fetch_valid_i && !response_live) begin
                discard_q <= discard_q - 1'b1;
            end
        end
    end

    // ------------------------------------------------------------
    // Buffer and memory strobes
    // ------------------------------------------------------------

    assign fetch_req_o     = issue;
    assign fetch_address_o = pc_q;
    assign write_address_o = issue;

    // Outcome of the lookup started in the previous ISSUE cycle
    assign write_speculative_o = (state_q == PREDICT) && !flush_i;
    assign speculative_o       = predict_hit_i;
    assign taken_o             = predict_hit_i && predict_taken_i;

    assign write_instruction_o = response_live && !flush_i;

endmodule : fetch_controller

`default_nettype wire

// ==== branch_target_buffer/branch_target_buffer.sv ====
`default_nettype none

module branch_target_buffer (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  lookup_i,
    input  fetch_pkg::data_word_t lookup_address_i,
    input  logic                  update_i,
    input  fetch_pkg::data_word_t update_address_i,
    input  fetch_pkg::data_word_t update_target_i,
    input  logic                  update_taken_i,
    output logic                  hit_o,
    output logic                  predict_taken_o,
    output fetch_pkg::data_word_t target_o
);
    import fetch_pkg::*;
    import btb_pkg::*;

    logic         valid_q   [BTB_ENTRIES];
    btb_tag_t     tag_q     [BTB_ENTRIES];
    data_word_t   target_q  [BTB_ENTRIES];
    btb_counter_t counter_q [BTB_ENTRIES];

    btb_index_t   lookup_index;
    btb_tag_t     lookup_tag;
    btb_index_t   update_index;
    btb_tag_t     update_tag;
    logic         update_match;
    btb_counter_t counter_cur;

    // ------------------------------------------------------------
    // Address split
    // ------------------------------------------------------------

    assign lookup_index = lookup_address_i[BTB_TAG_LSB-1:BTB_INDEX_LSB];
    assign lookup_tag   = lookup_address_i[31:BTB_TAG_LSB];
    assign update_index = update_address_i[BTB_TAG_LSB-1:BTB_INDEX_LSB];
    assign update_tag   = update_address_i[31:BTB_TAG_LSB];

    assign update_match = valid_q[update_index] && (tag_q[update_index] == update_tag);
    assign counter_cur  = counter_q[update_index];

    // ------------------------------------------------------------
    // Registered lookup
    // ------------------------------------------------------------

    // Nonblocking reads here see the entry before a same-edge update
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            hit_o <= 1'b0;
        end else begin
            hit_o <= lookup_i && valid_q[lookup_index]
                   && (tag_q[lookup_index] == lookup_tag);
        end
    end

    always_ff @(posedge clk_i) begin
        if (lookup_i) begin
            predict_taken_o <= counter_q[lookup_index][1];
            target_o        <= target_q[lookup_index];
        end
    end

    // ------------------------------------------------------------
    // Update port
    // ------------------------------------------------------------

    // Only a taken miss allocates, so the valid bit never clears after reset
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < BTB_ENTRIES; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else if (update_i && !update_match && update_taken_i) begin
            valid_q[update_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (update_i) begin
            if (update_match) begin
                // Saturating step toward the observed direction
                if (update_taken_i) begin
                    target_q[update_index] <= update_target_i;
                    if (counter_cur != 2'd3) begin
                        counter_q[update_index] <= counter_cur + 1'b1;
                    end
                end else if (counter_cur != 2'd0) begin
                    counter_q[update_index] <= counter_cur - 1'b1;
                end
            end else if (update_taken_i) begin
                // Taken miss replaces whatever lived in this slot
                tag_q[update_index]     <= update_tag;
                target_q[update_index]  <= update_target_i;
                counter_q[update_index] <= WEAK_TAKEN;
            end
        end
    end

endmodule : branch_target_buffer

`default_nettype wire

// ==== instruction_buffer/instruction_buffer.sv ====
`default_nettype none

module instruction_buffer #(
    parameter int unsigned BUFFER_SIZE = fetch_pkg::BUFFER_SIZE
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  flush_i,
    input  fetch_pkg::data_word_t fetch_instruction_i,
    input  fetch_pkg::data_word_t fetch_address_i,
    input  logic                  fetch_speculative_i,
    input  logic                  taken_i,
    input  logic                  write_instruction_i,
    input  logic                  write_speculative_i,
    input  logic                  write_address_i,
    input  logic                  read_i,
    output fetch_pkg::data_word_t fetch_instruction_o,
    output fetch_pkg::data_word_t fetch_address_o,
    output logic                  fetch_speculative_o,
    output logic                  taken_o,
    output logic                  empty_o,
    output logic                  full_o
);
    import fetch_pkg::*;

    // Pointers carry one extra wrap bit to tell full from empty
    localparam int unsigned PTR_BITS = $clog2(BUFFER_SIZE);

    logic [PTR_BITS:0] instr_ptr_q;
    logic [PTR_BITS:0] spec_ptr_q;
    logic [PTR_BITS:0] addr_ptr_q;
    logic [PTR_BITS:0] read_ptr_q;

    data_word_t instr_mem [BUFFER_SIZE];
    data_word_t addr_mem  [BUFFER_SIZE];
    logic [1:0] spec_mem  [BUFFER_SIZE];

    // ------------------------------------------------------------
    // Pointers
    // ------------------------------------------------------------

    // The three parts of an entry arrive in different cycles, each with
    // its own write pointer, and leave together through the read pointer
    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            instr_ptr_q <= '0;
            spec_ptr_q  <= '0;
            addr_ptr_q  <= '0;
            read_ptr_q  <= '0;
        end else begin
            if (write_instruction_i) begin
                instr_ptr_q <= instr_ptr_q + 1'b1;
            end
            if (write_speculative_i) begin
                spec_ptr_q <= spec_ptr_q + 1'b1;
            end
            if (write_address_i) begin
                addr_ptr_q <= addr_ptr_q + 1'b1;
            end
            if (read_i) begin
                read_ptr_q <= read_ptr_q + 1'b1;
            end
        end
    end

    // An entry is readable once its word is in, and the word comes last
    assign empty_o = (instr_ptr_q == read_ptr_q);

    // An issued address already holds its slot while its word is pending
    assign full_o = ({~addr_ptr_q[PTR_BITS], addr_ptr_q[PTR_BITS-1:0]} == read_ptr_q);

    // ------------------------------------------------------------
    // Storage
    // ------------------------------------------------------------

    // Slots that were never written show a no-op to decode
    initial begin
        for (int i = 0; i < BUFFER_SIZE; i++) begin
            instr_mem[i] = NOP_WORD;
            addr_mem[i]  = '0;
            spec_mem[i]  = 2'b00;
        end
    end

    always_ff @(posedge clk_i) begin
        if (write_instruction_i) begin
            instr_mem[instr_ptr_q[PTR_BITS-1:0]] <= fetch_instruction_i;
        end
        if (write_speculative_i) begin
            spec_mem[spec_ptr_q[PTR_BITS-1:0]] <= {fetch_speculative_i, taken_i};
        end
        if (write_address_i) begin
            addr_mem[addr_ptr_q[PTR_BITS-1:0]] <= fetch_address_i;
        end
    end

    // Head of the queue is shown without a register stage
    assign fetch_instruction_o = instr_mem[read_ptr_q[PTR_BITS-1:0]];
    assign fetch_address_o     = addr_mem[read_ptr_q[PTR_BITS-1:0]];
    assign {fetch_speculative_o, taken_o} = spec_mem[read_ptr_q[PTR_BITS-1:0]];

endmodule : instruction_buffer

`default_nettype wire

// ==== verilog/fetch_unit.sv ====
`default_nettype none

module fetch_unit (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  flush_i,
    input  fetch_pkg::data_word_t redirect_address_i,
    input  logic                  fetch_valid_i,
    input  fetch_pkg::data_word_t fetch_instruction_i,
    input  logic                  read_i,
    input  logic                  btb_update_i,
    input  fetch_pkg::data_word_t btb_update_address_i,
    input  fetch_pkg::data_word_t btb_update_target_i,
    input  logic                  btb_update_taken_i,
    output logic                  fetch_req_o,
    output fetch_pkg::data_word_t fetch_address_o,
    output logic                  instr_valid_o,
    output fetch_pkg::data_word_t instr_o,
    output fetch_pkg::data_word_t instr_address_o,
    output logic                  speculative_o,
    output logic                  taken_o
);
    import fetch_pkg::*;

    // Controller to buffer
    logic       write_address;
    logic       write_speculative;
    logic       write_instruction;
    logic       spec_bit;
    logic       taken_bit;
    logic       buffer_full;
    logic       buffer_empty;

    // Predictor to controller, one cycle after the lookup
    logic       predict_hit;
    logic       predict_taken;
    data_word_t predict_target;

    // ------------------------------------------------------------
    // Program counter stage
    // ------------------------------------------------------------

    fetch_controller i_fetch_controller (
        .clk_i               (clk_i),
        .rst_n_i             (rst_n_i),
        .flush_i             (flush_i),
        .redirect_address_i  (redirect_address_i),
        .buffer_full_i       (buffer_full),
        .fetch_valid_i       (fetch_valid_i),
        .predict_hit_i       (predict_hit),
        .predict_taken_i     (predict_taken),
        .predict_target_i    (predict_target),
        .fetch_req_o         (fetch_req_o),
        .fetch_address_o     (fetch_address_o),
        .write_address_o     (write_address),
        .write_speculative_o (write_speculative),
        .speculative_o       (spec_bit),
        .taken_o             (taken_bit),
        .write_instruction_o (write_instruction)
    );

    // The predictor looks up every issued address
    branch_target_buffer i_branch_target_buffer (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .lookup_i         (write_address),
        .lookup_address_i (fetch_address_o),
        .update_i         (btb_update_i),
        .update_address_i (btb_update_address_i),
        .update_target_i  (btb_update_target_i),
        .update_taken_i   (btb_update_taken_i),
        .hit_o            (predict_hit),
        .predict_taken_o  (predict_taken),
        .target_o         (predict_target)
    );

    // ------------------------------------------------------------
    // Decode-side queue
    // ------------------------------------------------------------

    instruction_buffer #(
        .BUFFER_SIZE (BUFFER_SIZE)
    ) i_instruction_buffer (
        .clk_i               (clk_i),
        .rst_n_i             (rst_n_i),
        .flush_i             (flush_i),
        .fetch_instruction_i (fetch_instruction_i),
        .fetch_address_i     (fetch_address_o),
        .fetch_speculative_i (spec_bit),
        .taken_i             (taken_bit),
        .write_instruction_i (write_instruction),
        .write_speculative_i (write_speculative),
        .write_address_i     (write_address),
        .read_i              (read_i),
        .fetch_instruction_o (instr_o),
        .fetch_address_o     (instr_address_o),
        .fetch_speculative_o (speculative_o),
        .taken_o             (taken_o),
        .empty_o             (buffer_empty),
        .full_o              (buffer_full)
    );

    assign instr_valid_o = ~buffer_empty;

endmodule : fetch_unit

`default_nettype wire

// ==== sim/clock_gen.sv ====
`default_nettype none

module clock_gen (
    output logic clk_o,
    output logic rst_n_o
);

    // Free-running clock with a period of 10 time units
    initial begin
        clk_o = 1'b0;
        forever begin
            #5 clk_o = ~clk_o;
        end
    end

    // Reset is held low over the first two rising edges and then released on an edge
    initial begin
        rst_n_o = 1'b0;
        repeat (2) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule : clock_gen

`default_nettype wire

// ==== sim/fetch_unit_properties.sv ====
`default_nettype none

module fetch_unit_properties (
    input logic                  clk_i,
    input logic                  rst_n_i,
    input logic                  fetch_req_i,
    input fetch_pkg::data_word_t fetch_address_i,
    input logic                  instr_valid_i,
    input logic                  read_i
);
    import fetch_pkg::*;

    int failure_count = 0;

    // Every issue is followed by a PREDICT cycle, so requests are never back to back
    req_spacing: assert property (@(posedge clk_i) (rst_n_i && fetch_req_i) |=> !fetch_req_i)
        else begin
            failure_count++;
            $error("fetch request raised on two consecutive cycles");
        end

    // Right after a reset edge no request leaves, the queue is empty
    // and the pc sits at the reset vector
    reset_state: assert property (@(posedge clk_i)
        !rst_n_i |=> (!fetch_req_i && !instr_valid_i && (fetch_address_i == RESET_VECTOR)))
        else begin
            failure_count++;
            $error("request, queue or pc not in the reset state after reset");
        end

    // Decode may only pop an entry that is there
    read_legal: assert property (@(posedge clk_i) (rst_n_i && read_i) |-> instr_valid_i)
        else begin
            failure_count++;
            $error("read_i raised while instr_valid_o is low");
        end

endmodule : fetch_unit_properties

bind fetch_unit fetch_unit_properties i_fetch_unit_properties (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .fetch_req_i     (fetch_req_o),
    .fetch_address_i (fetch_address_o),
    .instr_valid_i   (instr_valid_o),
    .read_i          (read_i)
);

`default_nettype wire

// ==== sim/fetch_unit_tb.sv ====
`default_nettype none

module fetch_unit_tb;
    import fetch_pkg::*;
    import btb_pkg::*;

    logic       clk_i;
    logic       rst_n_i;
    logic       flush_i;
    data_word_t redirect_address_i;
    logic       fetch_valid_i = 1'b0;
    data_word_t fetch_instruction_i = '0;
    logic       read_i = 1'b0;
    logic       btb_update_i;
    data_word_t btb_update_address_i;
    data_word_t btb_update_target_i;
    logic       btb_update_taken_i;
    logic       fetch_req_o;
    data_word_t fetch_address_o;
    logic       instr_valid_o;
    data_word_t instr_o;
    data_word_t instr_address_o;
    logic       speculative_o;
    logic       taken_o;

    // Reference predictor and the expected fetch pc
    data_word_t   exp_pc = RESET_VECTOR;
    logic         ref_valid   [BTB_ENTRIES];
    logic [25:0]  ref_tag     [BTB_ENTRIES];
    data_word_t   ref_target  [BTB_ENTRIES];
    btb_counter_t ref_counter [BTB_ENTRIES];

    // Memory model requests, oldest first, with the cycle each one answers in
    data_word_t mem_addr_q [$];
    int         mem_due_q  [$];
    int         mem_cycle = 0;
    int         last_due  = 0;

    int   read_count = 0;
    int   request_count = 0;
    int   occupancy = 0;
    int   taken_hits = 0;
    int   not_taken_hits = 0;
    int   mismatch_count = 0;
    int   error_count = 0;
    int   timeout_count = 0;
    logic reader_pause = 1'b0;
    logic response_seen = 1'b0;

    clock_gen i_clock_gen (
        .clk_o   (clk_i),
        .rst_n_o (rst_n_i)
    );

    fetch_unit i_fetch_unit (.*);

    // ------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------

    // The memory answers with a bijection of the address so that a stale word never matches
    function automatic data_word_t mix_word(input data_word_t addr);
        return {addr[15:0], ~addr[31:16]} ^ 32'h5A3C_96E1;
    endfunction

    // Taken hits train up and move the target, not-taken hits train down, taken misses allocate
    function automatic void ref_update(input data_word_t addr, input data_word_t target,
                                       input logic taken);
        logic [3:0] idx;
        idx = addr[5:2];
        if (ref_valid[idx] && ref_tag[idx] == addr[31:6]) begin
            if (taken) begin
                ref_target[idx] = target;
                if (ref_counter[idx] != 2'd3) ref_counter[idx] = ref_counter[idx] + 2'd1;
            end else if (ref_counter[idx] != 2'd0) begin
                ref_counter[idx] = ref_counter[idx] - 2'd1;
            end
        end else if (taken) begin
            ref_valid[idx]   = 1'b1;
            ref_tag[idx]     = addr[31:6];
            ref_target[idx]  = target;
            ref_counter[idx] = WEAK_TAKEN;
        end
    endfunction

    // Produces the entry for the expected pc and steps the pc the way the front end should
    function automatic void ref_next(output data_word_t addr, output data_word_t word,
                                     output logic spec, output logic taken);
        logic [3:0] idx;
        idx    = exp_pc[5:2];
        addr   = exp_pc;
        word   = mix_word(exp_pc);
        spec   = ref_valid[idx] && (ref_tag[idx] == exp_pc[31:6]);
        taken  = spec && ref_counter[idx][1];
        exp_pc = taken ? ref_target[idx] : exp_pc + 32'd4;
    endfunction

    task automatic compare_word(input data_word_t actual, input data_word_t expected,
                                input string name);
        if (actual !== expected) begin
            mismatch_count++;
            $display("Mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic compare_flag(input logic actual, input logic expected, input string name);
        if (actual !== expected) begin
            mismatch_count++;
            $display("Mismatch at %0t: %s is %b, expected %b", $time, name, actual, expected);
        end
    endtask

    task automatic report_error(input string msg);
        error_count++;
        $display("Error at %0t: %s", $time, msg);
    endtask

    // ------------------------------------------------------------
    // Memory model, decode reader and checkers
    // ------------------------------------------------------------

    // In-order responses 1 to 4 cycles after their request, never two in one cycle
    always @(posedge clk_i) begin : memory_model
        int due;
        if (!rst_n_i) begin
            fetch_valid_i <= 1'b0;
            mem_addr_q.delete();
            mem_due_q.delete();
        end else begin
            mem_cycle = mem_cycle + 1;
            if (fetch_req_o) begin
                due = mem_cycle + int'($urandom % 4);
                if (due <= last_due) due = last_due + 1;
                last_due = due;
                mem_addr_q.push_back(fetch_address_o);
                mem_due_q.push_back(due);
            end
            if (mem_due_q.size() > 0 && mem_due_q[0] == mem_cycle) begin
                fetch_valid_i       <= 1'b1;
                fetch_instruction_i <= mix_word(mem_addr_q.pop_front());
                void'(mem_due_q.pop_front());
            end else begin
                fetch_valid_i <= 1'b0;
            end
        end
    end

    // Single-cycle reads with random gaps, only while an entry is sure to stay valid
    always @(posedge clk_i) begin : decode_reader
        if (!rst_n_i || read_i) begin
            read_i <= 1'b0;
        end else if (!reader_pause && !flush_i && instr_valid_o && ($urandom % 3 != 0)) begin
            read_i <= 1'b1;
        end
    end

    always @(posedge clk_i) begin : compare_reads
        data_word_t exp_addr;
        data_word_t exp_word;
        logic       exp_spec;
        logic       exp_taken;
        if (rst_n_i && read_i && instr_valid_o) begin
            ref_next(exp_addr, exp_word, exp_spec, exp_taken);
            compare_word(instr_address_o, exp_addr, "instr_address_o");
            compare_word(instr_o, exp_word, "instr_o");
            compare_flag(speculative_o, exp_spec, "speculative_o");
            compare_flag(taken_o, exp_taken, "taken_o");
            if (speculative_o && taken_o) taken_hits++;
            if (speculative_o && !taken_o) not_taken_hits++;
            read_count++;
        end
    end

    // Tracks addresses held in the buffer since the last flush
    always @(posedge clk_i) begin : request_monitor
        if (rst_n_i) begin
            if (!response_seen && instr_valid_o) begin
                report_error("instr_valid_o rose before any memory response");
            end
            if (fetch_valid_i) response_seen = 1'b1;
            if (fetch_req_o && request_count == 0) begin
                compare_word(fetch_address_o, RESET_VECTOR, "fetch_address_o");
            end
            if (fetch_req_o) request_count++;
            if (flush_i) begin
                occupancy = 0;
            end else begin
                if (fetch_req_o && occupancy >= BUFFER_SIZE) begin
                    report_error("request issued with the buffer already full");
                end
                occupancy = occupancy + int'(fetch_req_o) - int'(read_i && instr_valid_o);
            end
        end
    end

    // ------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------

    task automatic wait_cycles(input int count);
        repeat (count) @(posedge clk_i);
    endtask

    // The read count is looked at on the falling edge, where it is settled
    task automatic wait_reads(input int count);
        int target;
        int waited;
        target = read_count + count;
        waited = 0;
        if (timeout_count != 0) return;
        while (read_count < target && waited < count * 20) begin
            @(negedge clk_i);
            waited++;
        end
        if (read_count < target) begin
            timeout_count++;
            $display("Timeout at %0t: decode got only %0d of %0d entries",
                     $time, count - (target - read_count), count);
        end
    endtask

    // Waits until responses are pending and the buffer holds entries
    task automatic wait_in_flight();
        int waited;
        waited = 0;
        @(negedge clk_i);
        while (!(mem_addr_q.size() > 0 && instr_valid_o) && waited < 100) begin
            @(negedge clk_i);
            waited++;
        end
        if (!(mem_addr_q.size() > 0 && instr_valid_o)) begin
            timeout_count++;
            $display("Timeout at %0t: no request in flight with a filled buffer", $time);
        end
    endtask

    // Two edges make sure no read is still pending before the expected stream changes
    task automatic pause_reader();
        reader_pause = 1'b1;
        wait_cycles(2);
    endtask

    task automatic send_update(input data_word_t addr, input data_word_t target,
                               input logic taken);
        @(posedge clk_i);
        btb_update_i         <= 1'b1;
        btb_update_address_i <= addr;
        btb_update_target_i  <= target;
        btb_update_taken_i   <= taken;
        ref_update(addr, target, taken);
        @(posedge clk_i);
        btb_update_i <= 1'b0;
    endtask

    task automatic send_flush(input data_word_t addr);
        @(posedge clk_i);
        flush_i            <= 1'b1;
        redirect_address_i <= addr;
        exp_pc = addr;
        @(posedge clk_i);
        flush_i <= 1'b0;
    endtask

    initial begin : stimulus
        int waited;
        int held_requests;
        void'($urandom(44));
        flush_i              = 1'b0;
        redirect_address_i   = '0;
        btb_update_i         = 1'b0;
        btb_update_address_i = '0;
        btb_update_target_i  = '0;
        btb_update_taken_i   = 1'b0;
        for (int i = 0; i < BTB_ENTRIES; i++) begin
            ref_valid[i] = 1'b0;
        end

        waited = 0;
        while (!rst_n_i && waited < 10) begin
            @(posedge clk_i);
            waited++;
        end
        if (!rst_n_i) begin
            timeout_count++;
            $display("Timeout at %0t: reset was never released", $time);
        end

        // Sequential stream from the reset vector with an empty predictor
        wait_reads(40);

        // Taken branch at 0x108 to 0x200, fetched again from 0x100
        pause_reader();
        send_update(32'h0000_0108, 32'h0000_0200, 1'b1);
        send_flush(32'h0000_0100);
        reader_pause = 1'b0;
        wait_reads(12);
        if (taken_hits == 0) report_error("no taken prediction was decoded for the branch");

        // Two not-taken outcomes bring the entry down to strongly not taken
        pause_reader();
        send_update(32'h0000_0108, 32'h0000_0200, 1'b0);
        send_update(32'h0000_0108, 32'h0000_0200, 1'b0);
        send_flush(32'h0000_0100);
        reader_pause = 1'b0;
        wait_reads(12);
        if (not_taken_hits == 0) report_error("no not-taken hit was decoded for the branch");

        // Flush with responses still on their way and entries waiting in the buffer
        pause_reader();
        wait_in_flight();
        send_flush(32'h0000_0400);
        reader_pause = 1'b0;
        wait_reads(20);

        // Long decode stall fills the buffer and must stop the requests
        reader_pause = 1'b1;
        wait_cycles(60);
        held_requests = request_count;
        wait_cycles(20);
        if (request_count != held_requests) report_error("requests went on with the buffer full");
        if (occupancy != BUFFER_SIZE) report_error("buffer did not fill during the decode stall");
        reader_pause = 1'b0;
        wait_reads(BUFFER_SIZE + 20);

        error_count = error_count + i_fetch_unit.i_fetch_unit_properties.failure_count;
        $display("Reads checked %0d, mismatches %0d, errors %0d, timeouts %0d",
                 read_count, mismatch_count, error_count, timeout_count);
        if (mismatch_count == 0 && error_count == 0 && timeout_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule : fetch_unit_tb

`default_nettype wire

// ==== compile.f ====
common/fetch_pkg.sv
common/btb_pkg.sv
verilog/fetch_controller.sv
branch_target_buffer/branch_target_buffer.sv
instruction_buffer/instruction_buffer.sv
verilog/fetch_unit.sv
sim/clock_gen.sv
sim/fetch_unit_properties.sv
sim/fetch_unit_tb.sv

// ==== Bender.yml ====
package:
  name: fetch_unit

sources:
  - files:
      - common/fetch_pkg.sv
      - common/btb_pkg.sv
      - verilog/fetch_controller.sv
      - branch_target_buffer/branch_target_buffer.sv
      - instruction_buffer/instruction_buffer.sv
      - verilog/fetch_unit.sv
  - target: test
    files:
      - sim/clock_gen.sv
      - sim/fetch_unit_properties.sv
      - sim/fetch_unit_tb.sv
